//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath width
`define XLEN 32

// Memory geometry in words
`define IMEM_WORDS 256
`define DMEM_WORDS 256
`define MEM_AW 8

// RV32I major opcodes
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111

// funct7 values for the base and alternate forms
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// Word access only
`define F3_WORD 3'b010

`endif

//--- hdl/corePkg.sv
`include "core_defs.svh"

package corePkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [`MEM_AW-1:0] memAddrT;

    typedef enum logic [1:0] {
        stFetch,
        stDecode,
        stExecute,
        stWriteback
    } stateT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra,
        aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu
    } aluOpT;

    typedef enum logic [1:0] {immI, immS, immB, immJ} immKindT;

    typedef enum logic {aRs1, aPc} aSelT;

    typedef enum logic [1:0] {bRs2, bImm, bFour} bSelT;

    typedef enum logic [1:0] {wbAlu, wbLoad, wbPcPlus4} wbSelT;

    typedef struct packed {
        logic    irWrite;
        logic    pcWrite;
        logic    regWrite;
        logic    memWrite;
        aSelT    aSel;
        bSelT    bSel;
        aluOpT   aluOp;
        immKindT immKind;
        wbSelT   wbSel;
        logic    pcFromAlu;     // Jump target from aluOut
        logic    pcFromBranch;  // Taken branch, pc plus immediate
        logic    retire;
    } ctrlT;

endpackage

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu
    import corePkg::*;
(
    input  aluOpT op,
    input  wordT  a,
    input  wordT  b,
    output wordT  result,
    output logic  cmpTrue
);

    logic       eq;
    logic       lt;
    logic       ltu;
    logic [4:0] shamt;

    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);
    assign shamt = b[4:0];

    always_comb begin
        cmpTrue = 1'b0;
        result  = '0;
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluSll: result = a << shamt;
            aluSrl: result = a >> shamt;
            aluSra: result = wordT'($signed(a) >>> shamt);
            aluSlt,
            aluLt:  cmpTrue = lt;
            aluSltu,
            aluLtu: cmpTrue = ltu;
            aluEq:  cmpTrue = eq;
            aluNe:  cmpTrue = !eq;
            aluGe:  cmpTrue = !lt;
            aluGeu: cmpTrue = !ltu;
            default: ;
        endcase
        case (op)
            aluSlt, aluSltu, aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu:
                result = wordT'(cmpTrue);  // Relation as 0 or 1
            default: ;
        endcase
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps

module regFile
    import corePkg::*;
(
    input  logic    clk,
    input  logic    we,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  wordT    wd,
    output wordT    rd1,
    output wordT    rd2
);

    wordT regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/immGen.sv
`timescale 1ns/100ps

module immGen
    import corePkg::*;
(
    input  wordT    instr,
    input  immKindT kind,
    output wordT    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (kind)
            immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};  // I format, also shift amounts
            end
        endcase
    end

endmodule

//--- hdl/wordMem.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module wordMem
    import corePkg::*;
#(
    parameter int DEPTH = 1 << `MEM_AW
) (
    input  logic    clk,
    input  logic    we,
    input  memAddrT waddr,
    input  memAddrT raddr,
    input  wordT    wdata,
    output wordT    rdata
);

    wordT mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

endmodule

//--- hdl/controlFsm.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module controlFsm
    import corePkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  logic  run,
    input  wordT  instr,
    input  logic  cmpTrue,
    output ctrlT  ctrl,
    output stateT state
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7Base;
    logic       f7Alt;

    logic    dWritesRd;
    logic    dStore;
    logic    dBranch;
    logic    dJump;
    aSelT    dASel;
    bSelT    dBSel;
    aluOpT   dAluOp;
    immKindT dImmKind;
    wbSelT   dWbSel;

    logic takenQ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign f7Base = (funct7 == `F7_BASE);
    assign f7Alt  = (funct7 == `F7_ALT);

    // Shared by register and immediate ALU forms
    function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            3'b000:  return (isReg && alt) ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic aluOpT branchOp(input logic [2:0] f3);
        case (f3)
            3'b001:  return aluNe;
            3'b100:  return aluLt;
            3'b101:  return aluGe;
            3'b110:  return aluLtu;
            3'b111:  return aluGeu;
            default: return aluEq;
        endcase
    endfunction

    // Instruction decode, independent of state
    always_comb begin
        dWritesRd = 1'b0;
        dStore    = 1'b0;
        dBranch   = 1'b0;
        dJump     = 1'b0;
        dASel     = aRs1;
        dBSel     = bRs2;
        dAluOp    = aluAdd;
        dImmKind  = immI;
        dWbSel    = wbAlu;
        case (opcode)
            `OPC_OP: begin
                if (f7Base || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dWritesRd = 1'b1;
                    dAluOp    = arithOp(funct3, funct7[5], 1'b1);
                end
            end
            `OPC_OPIMM: begin
                dBSel = bImm;
                if (funct3 == 3'b001) begin
                    dWritesRd = f7Base;
                end else if (funct3 == 3'b101) begin
                    dWritesRd = f7Base || f7Alt;
                end else begin
                    dWritesRd = 1'b1;
                end
                dAluOp = arithOp(funct3, funct7[5], 1'b0);
            end
            `OPC_LOAD: begin
                dBSel     = bImm;
                dWritesRd = (funct3 == `F3_WORD);
                dWbSel    = wbLoad;
            end
            `OPC_STORE: begin
                dBSel    = bImm;
                dImmKind = immS;
                dStore   = (funct3 == `F3_WORD);
            end
            `OPC_BRANCH: begin
                dImmKind = immB;
                dBranch  = (funct3[2:1] != 2'b01);
                dAluOp   = branchOp(funct3);
            end
            `OPC_JAL: begin
                dASel     = aPc;
                dBSel     = bImm;
                dImmKind  = immJ;
                dWritesRd = 1'b1;
                dJump     = 1'b1;
                dWbSel    = wbPcPlus4;
            end
            `OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    dBSel     = bImm;
                    dWritesRd = 1'b1;
                    dJump     = 1'b1;
                    dWbSel    = wbPcPlus4;
                end
            end
            default: ;  // Unknown opcode retires as a nop
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else if (run || state != stFetch) begin
            case (state)
                stFetch:   state <= stDecode;
                stDecode:  state <= stExecute;
                stExecute: state <= stWriteback;
                default:   state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            takenQ <= 1'b0;
        end else if (state == stExecute) begin
            takenQ <= dBranch & cmpTrue;
        end
    end

    always_comb begin
        ctrl         = '0;
        ctrl.immKind = dImmKind;
        ctrl.wbSel   = dWbSel;
        case (state)
            stFetch: begin
                ctrl.irWrite = run;
            end
            stExecute: begin
                ctrl.aSel  = dASel;
                ctrl.bSel  = dBSel;
                ctrl.aluOp = dAluOp;
            end
            stWriteback: begin
                // ALU is free here and produces pc plus four
                ctrl.aSel         = aPc;
                ctrl.bSel         = bFour;
                ctrl.aluOp        = aluAdd;
                ctrl.regWrite     = dWritesRd;
                ctrl.memWrite     = dStore;
                ctrl.pcWrite      = 1'b1;
                ctrl.pcFromAlu    = dJump;
                ctrl.pcFromBranch = dBranch & takenQ;
                ctrl.retire       = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module cpuTop
    import corePkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    run,
    input  logic    loadEn,
    input  memAddrT loadAddr,
    input  wordT    loadData,
    output logic    wbEn,
    output regAddrT wbReg,
    output wordT    wbData,
    output logic    stEn,
    output wordT    stAddr,
    output wordT    stData,
    output logic    retire,
    output wordT    retirePc
);

    ctrlT  ctrl;
    stateT state;

    wordT pc;
    wordT ir;
    wordT rs1Q;
    wordT rs2Q;
    wordT immQ;
    wordT aluOut;

    wordT    imemData;
    wordT    dmemData;
    wordT    rd1;
    wordT    rd2;
    wordT    immVal;
    wordT    aluA;
    wordT    aluB;
    wordT    aluResult;
    logic    cmpTrue;
    wordT    wdMux;
    wordT    nextPc;
    regAddrT rd;
    memAddrT dAddr;

    assign rd    = ir[11:7];
    assign dAddr = aluOut[`MEM_AW+1:2];  // Byte address to word index

    controlFsm controlFsm_inst (
        .clk     (clk),
        .arstN   (arstN),
        .run     (run),
        .instr   (ir),
        .cmpTrue (cmpTrue),
        .ctrl    (ctrl),
        .state   (state)
    );

    wordMem #(.DEPTH(`IMEM_WORDS)) imem_inst (
        .clk   (clk),
        .we    (loadEn && !run),
        .waddr (loadAddr),
        .raddr (pc[`MEM_AW+1:2]),
        .wdata (loadData),
        .rdata (imemData)
    );

    wordMem #(.DEPTH(`DMEM_WORDS)) dmem_inst (
        .clk   (clk),
        .we    (ctrl.memWrite),
        .waddr (dAddr),
        .raddr (dAddr),
        .wdata (rs2Q),
        .rdata (dmemData)
    );

    regFile regFile_inst (
        .clk (clk),
        .we  (ctrl.regWrite),
        .rs1 (ir[19:15]),
        .rs2 (ir[24:20]),
        .rd  (rd),
        .wd  (wdMux),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    immGen immGen_inst (
        .instr (ir),
        .kind  (ctrl.immKind),
        .imm   (immVal)
    );

    assign aluA = (ctrl.aSel == aPc) ? pc : rs1Q;

    always_comb begin
        case (ctrl.bSel)
            bImm:    aluB = immQ;
            bFour:   aluB = wordT'(4);
            default: aluB = rs2Q;
        endcase
    end

    alu alu_inst (
        .op      (ctrl.aluOp),
        .a       (aluA),
        .b       (aluB),
        .result  (aluResult),
        .cmpTrue (cmpTrue)
    );

    // In Writeback the ALU result is pc plus four
    always_comb begin
        case (ctrl.wbSel)
            wbLoad:    wdMux = dmemData;
            wbPcPlus4: wdMux = aluResult;
            default:   wdMux = aluOut;
        endcase
    end

    always_comb begin
        if (ctrl.pcFromAlu) begin
            nextPc = {aluOut[`XLEN-1:1], 1'b0};
        end else if (ctrl.pcFromBranch) begin
            nextPc = pc + immQ;
        end else begin
            nextPc = aluResult;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (ctrl.irWrite) begin
                ir <= imemData;
            end
            if (ctrl.pcWrite) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            rs1Q <= rd1;
            rs2Q <= rd2;
            immQ <= immVal;
        end
        if (state == stExecute) begin
            aluOut <= aluResult;
        end
    end

    assign wbEn     = ctrl.regWrite && (rd != '0);
    assign wbReg    = rd;
    assign wbData   = wdMux;
    assign stEn     = ctrl.memWrite;
    assign stAddr   = aluOut;
    assign stData   = rs2Q;
    assign retire   = ctrl.retire;
    assign retirePc = pc;  // pc still holds the retiring instruction

endmodule

//--- sim/cpuSva.sv
`timescale 1ns/100ps

module cpuSva
    import corePkg::*;
(
    input logic    clk,
    input logic    arstN,
    input logic    run,
    input logic    wbEn,
    input regAddrT wbReg,
    input logic    stEn,
    input logic    retire
);

    int failCount = 0;

    // Three quiet cycles after every retire
    retireSpacing: assert property (@(posedge clk) disable iff (!arstN)
        retire |=> !retire ##1 !retire ##1 !retire)
        else begin
            failCount++;
            $error("retire pulsed again within four cycles");
        end

    retireCadence: assert property (@(posedge clk) disable iff (!arstN)
        retire ##1 run |-> ##3 retire)  // Fetch left while run high
        else begin
            failCount++;
            $error("retire missing four cycles after the previous one");
        end

    strobeWithRetire: assert property (@(posedge clk) disable iff (!arstN)
        (wbEn || stEn) |-> retire)
        else begin
            failCount++;
            $error("write strobe outside the retire cycle");
        end

    wbRegNonZero: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |-> wbReg != '0)
        else begin
            failCount++;
            $error("writeback reported for x0");
        end

    resetQuiet: assert property (@(posedge clk)
        $rose(arstN) |-> !(wbEn || stEn || retire))
        else begin
            failCount++;
            $error("strobe active right after reset");
        end

endmodule

//--- sim/cpuTb.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module cpuTb
    import corePkg::*;
();

    localparam int pauseAt     = 60;
    localparam int pauseCycles = 10;

    logic    clk;
    logic    arstN;
    logic    run;
    logic    loadEn;
    memAddrT loadAddr;
    wordT    loadData;
    logic    wbEn;
    regAddrT wbReg;
    wordT    wbData;
    logic    stEn;
    wordT    stAddr;
    wordT    stData;
    logic    retire;
    wordT    retirePc;

    wordT prog [256];
    int   progLen = 0;
    wordT endPc;
    wordT mPc;
    wordT mRegs [32];
    wordT mDm [256];
    int   retired = 0;
    logic done = 1'b0;
    int   errors = 0;
    int   svaErrors;

    logic [2:0] brF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    cpuTop cpuTop_inst (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .stEn     (stEn),
        .stAddr   (stAddr),
        .stData   (stData),
        .retire   (retire),
        .retirePc (retirePc)
    );

    bind cpuTop cpuSva cpuSva_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic wordT encR(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                  input logic [2:0] f3, input regAddrT rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic wordT encI(input logic [11:0] imm, input regAddrT rs1,
                                  input logic [2:0] f3, input regAddrT rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1);
        return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic wordT encB(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                                  input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic wordT encJ(input logic [20:0] imm, input regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic regAddrT pickReg(input int lo);
        return regAddrT'($urandom_range(lo, 31));
    endfunction

    function automatic void emit(input wordT w);
        prog[progLen] = w;
        progLen++;
    endfunction

    function automatic void emitFiller();
        emit(encI(12'($urandom), pickReg(1), 3'b000, pickReg(1), `OPC_OPIMM));
    endfunction

    // RV32I result rules for funct3
    function automatic wordT expectedAlu(input logic [2:0] f3, input logic alt,
                                         input wordT x, input wordT y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? wordT'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input wordT x, input wordT y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic buildProgram();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        regAddrT     rs;
        regAddrT     rt;
        int          off;
        int          tgt;
        for (int i = 1; i < 32; i++) begin
            emit(encI(12'($urandom), 5'd0, 3'b000, regAddrT'(i), `OPC_OPIMM));  // Known start
        end
        for (int i = 0; i < 40; i++) begin
            f3  = 3'($urandom);
            alt = 1'($urandom) && (f3 == 3'b000 || f3 == 3'b101);
            if ($urandom_range(0, 1) == 1) begin
                emit(encR(alt ? `F7_ALT : `F7_BASE, pickReg(0), pickReg(0), f3, pickReg(0)));
            end else begin
                imm = 12'($urandom);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {(alt && f3 == 3'b101) ? `F7_ALT : `F7_BASE, imm[4:0]};
                end
                emit(encI(imm, pickReg(0), f3, pickReg(0), `OPC_OPIMM));
            end
        end
        for (int i = 0; i < 4; i++) begin
            off = 4 * int'($urandom_range(0, 255));
            emit(encS(12'(off), pickReg(1), 5'd0));
            emit(encI(12'(off), 5'd0, `F3_WORD, pickReg(1), `OPC_LOAD));
        end
        foreach (brF3[k]) begin
            rs = pickReg(1);
            rt = pickReg(1);
            emit(encB(13'd8, rs, rs, brF3[k]));  // Equal operands
            emitFiller();
            emit(encI(12'd1, 5'd0, 3'b000, rt, `OPC_OPIMM));
            emit(encB(13'd8, rt, 5'd0, brF3[k]));  // Zero below one flips every outcome
            emitFiller();
        end
        emit(encI(12'($urandom), pickReg(1), 3'b000, 5'd0, `OPC_OPIMM));
        emit(encR(`F7_BASE, pickReg(1), pickReg(1), 3'b000, 5'd0));
        emit(($urandom & 32'hFFFF_FF80) | 32'h7F);  // Undefined opcode
        for (int i = 0; i < 2; i++) begin
            emit(encJ(21'd8, pickReg(1)));
            emitFiller();
        end
        for (int i = 0; i < 2; i++) begin
            rt  = pickReg(1);
            off = int'($urandom_range(0, 16)) - 8;
            tgt = (progLen + 3) * 4;  // Past the filler
            emit(encI(12'(tgt + 1 - off), 5'd0, 3'b000, rt, `OPC_OPIMM));  // Odd on purpose
            emit(encI(12'(off), rt, 3'b000, pickReg(1), `OPC_JALR));
            emitFiller();
        end
        endPc = wordT'(progLen * 4);
        emit(encJ(21'd0, 5'd0));  // Spin
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = memAddrT'(i);
            loadData = prog[i];
        end
        @(posedge clk);
        #2;
        loadEn = 1'b0;
    endtask

    task automatic checkEq(input string tn, input string what, input wordT exp, input wordT act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", tn, what, exp, act);
        end
    endtask

    // Model steps once per retired instruction
    task automatic checkRetire();
        wordT       ins;
        wordT       a;
        wordT       b;
        wordT       immI;
        wordT       res;
        wordT       nxt;
        wordT       sAddr;
        logic [2:0] f3;
        regAddrT    rd;
        logic       wr;
        logic       st;
        string      tn;
        ins   = prog[mPc[9:2]];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = mRegs[ins[19:15]];
        b     = mRegs[ins[24:20]];
        immI  = {{20{ins[31]}}, ins[31:20]};
        wr    = 1'b0;
        st    = 1'b0;
        res   = '0;
        sAddr = '0;
        nxt   = mPc + 4;
        case (ins[6:0])
            `OPC_OP: begin
                tn  = "alu";
                wr  = 1'b1;
                res = expectedAlu(f3, ins[30], a, b);
            end
            `OPC_OPIMM: begin
                tn  = "aluImm";
                wr  = 1'b1;
                res = expectedAlu(f3, ins[30] && f3 == 3'b101, a, immI);
            end
            `OPC_LOAD: begin
                tn    = "load";
                wr    = 1'b1;
                sAddr = a + immI;
                res   = mDm[sAddr[9:2]];
            end
            `OPC_STORE: begin
                tn    = "store";
                st    = 1'b1;
                sAddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            `OPC_BRANCH: begin
                tn = "branch";
                if (branchTaken(f3, a, b)) begin
                    nxt = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            `OPC_JAL: begin
                tn  = "jal";
                wr  = 1'b1;
                res = mPc + 4;
                nxt = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            `OPC_JALR: begin
                tn  = "jalr";
                wr  = 1'b1;
                res = mPc + 4;
                nxt = (a + immI) & ~32'h1;
            end
            default: tn = "unknown";
        endcase
        checkEq(tn, "retirePc", mPc, retirePc);
        checkEq(tn, "wbEn", wordT'(wr && rd != '0), wordT'(wbEn));
        if (wr && rd != '0) begin
            checkEq(tn, "wbReg", wordT'(rd), wordT'(wbReg));
            checkEq(tn, "wbData", res, wbData);
            mRegs[rd] = res;
        end
        checkEq(tn, "stEn", wordT'(st), wordT'(stEn));
        if (st) begin
            checkEq(tn, "stAddr", sAddr, stAddr);
            checkEq(tn, "stData", b, stData);
            mDm[sAddr[9:2]] = b;
        end
        mPc = nxt;
        retired++;
        if (mPc == endPc) begin
            done = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (retire) begin
            checkRetire();
        end
    end

    initial begin
        wait (run === 1'b1);
        #((progLen * 4 + pauseCycles + 64) * 20);
        $display("Watchdog expired before the program reached its end");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(39554));
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        mPc      = '0;
        foreach (mRegs[i]) begin
            mRegs[i] = '0;
        end
        buildProgram();
        repeat (16) @(posedge clk);
        #2;
        arstN = 1'b1;
        loadProgram();
        @(posedge clk);
        #2;
        run = 1'b1;
        wait (retired == pauseAt);
        @(posedge clk);  // Now in Fetch
        #2;
        run = 1'b0;
        repeat (pauseCycles) begin
            @(negedge clk);
            assert (!wbEn && !stEn && !retire) else begin
                errors++;
                $display("A strobe was active while run was low");
            end
        end
        @(posedge clk);
        #2;
        run = 1'b1;
        wait (done);
        repeat (4) @(posedge clk);
        svaErrors = cpuTop_inst.cpuSva_inst.failCount;
        $display("Retired %0d, check errors %0d, assertion errors %0d",
                 retired, errors, svaErrors);
        if (errors == 0 && svaErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/corePkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/immGen.sv
hdl/wordMem.sv
hdl/controlFsm.sv
hdl/cpuTop.sv
sim/cpuSva.sv
sim/cpuTb.sv

//--- Makefile
TOP := cpuTb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
		! grep -q "Simulation completed successfully" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
